// ==== compile.f ====
logic/cpu_pkg.sv
logic/cpu_control.sv
logic/instr_reg.sv
logic/reg_file.sv
logic/alu_datapath.sv
logic/addr_unit.sv
logic/cpu_top.sv
sim/tb_mem.sv
sim/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -f compile.f -o cpu_sim

out="$(./obj_dir/cpu_sim)"
echo "$out"

if grep -qx '\*\* PASS \*\*' <<< "$out"; then
	exit 0
else
	exit 1
fi

// ==== sim/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

	logic clk = 1'b0;
	logic rst = 1'b1;
	cpu_pkg::word_t     mem_rdata;
	cpu_pkg::mem_addr_t mem_addr;
	cpu_pkg::mem_cmd_t  mem_cmd;
	cpu_pkg::word_t     mem_wdata;
	logic [2:0]         status;
	logic               halt;

	// Expected-state model.
	cpu_pkg::word_t m_regs [8];
	logic [2:0]     m_status = '0;
	logic [2:0]     exp_status [64]; // Status seen when instruction k is fetched.
	int             exp_cycles [64];
	int prog_len  = 0;
	int str_count = 0;
	integer seed  = 32'he862;

	// Fetch tracking.
	int exp_pc   = 0;
	int read_run = 0;
	int cyc      = 0;
	int errors   = 0;
	int timeouts = 0;

	always #4 clk = ~clk;

	cpu_top cpu_top_inst (
		.clk       (clk),
		.rst       (rst),
		.mem_rdata (mem_rdata),
		.mem_addr  (mem_addr),
		.mem_cmd   (mem_cmd),
		.mem_wdata (mem_wdata),
		.status    (status),
		.halt      (halt)
	);

	tb_mem mem_inst (
		.clk       (clk),
		.mem_addr  (mem_addr),
		.mem_cmd   (mem_cmd),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

	always @(posedge clk) begin
		if (rst) begin
			exp_pc   <= 0;
			read_run <= 0;
			cyc      <= 0;
		end else if (mem_cmd == cpu_pkg::MEM_READ) begin
			read_run <= read_run + 1;
			if (read_run == 1)
				exp_pc <= exp_pc + 1; // Second read of a fetch pair.
			cyc <= (read_run == 0) ? 1 : cyc + 1;
		end else begin
			read_run <= 0;
			cyc      <= cyc + 1;
		end
	end

	a_reset_quiet: assert property (@(posedge clk)
		$fell(rst) |-> mem_cmd == cpu_pkg::MEM_NONE && !halt)
		else begin
			errors++;
			$display("** Error @%0t: bus or halt active after reset", $time);
		end

	a_fetch_order: assert property (@(posedge clk) disable iff (rst)
		mem_cmd == cpu_pkg::MEM_READ |->
			mem_addr == exp_pc[8:0] && read_run < 2 && exp_pc < prog_len)
		else begin
			errors++;
			$display("** Error @%0t: fetch at %0h, expected %0h",
				$time, $sampled(mem_addr), $sampled(exp_pc));
		end

	a_cycle_count: assert property (@(posedge clk) disable iff (rst)
		mem_cmd == cpu_pkg::MEM_READ && read_run == 0 && exp_pc != 0 |->
			cyc == exp_cycles[exp_pc-1])
		else begin
			errors++;
			$display("** Error @%0t: instruction %0d took %0d cycles",
				$time, $sampled(exp_pc) - 1, $sampled(cyc));
		end

	a_status: assert property (@(posedge clk) disable iff (rst)
		mem_cmd == cpu_pkg::MEM_READ && read_run == 0 |-> status == exp_status[exp_pc])
		else begin
			errors++;
			$display("** Error @%0t: status %b, expected %b",
				$time, $sampled(status), exp_status[$sampled(exp_pc)]);
		end

	a_halt_place: assert property (@(posedge clk) disable iff (rst)
		$rose(halt) |-> exp_pc == prog_len)
		else begin
			errors++;
			$display("** Error @%0t: halt after %0d fetches", $time, $sampled(exp_pc));
		end

	a_halt_idle: assert property (@(posedge clk) disable iff (rst)
		halt |-> mem_cmd == cpu_pkg::MEM_NONE)
		else begin
			errors++;
			$display("** Error @%0t: memory access while halted", $time);
		end

	function automatic cpu_pkg::word_t shift_val(cpu_pkg::word_t v, logic [1:0] sh);
		case (sh)
			2'b01:   return v << 1;
			2'b10:   return v >> 1;
			2'b11:   return {v[15], v[15:1]};
			default: return v;
		endcase
	endfunction

	function automatic cpu_pkg::word_t encode(logic [2:0] opc, logic [1:0] op, logic [2:0] rn,
			logic [2:0] rd, logic [1:0] sh, logic [2:0] rm);
		cpu_pkg::word_t w;
		w = (16'(opc) << cpu_pkg::OPC_LSB) | (16'(op) << cpu_pkg::OP_LSB);
		w = w | (16'(rn) << cpu_pkg::RN_LSB) | (16'(rd) << cpu_pkg::RD_LSB);
		w = w | (16'(sh) << cpu_pkg::SH_LSB) | (16'(rm) << cpu_pkg::RM_LSB);
		return w;
	endfunction

	task automatic emit(cpu_pkg::word_t w, int cycles);
		mem_inst.mem[prog_len] = w;
		exp_cycles[prog_len]   = cycles;
		exp_status[prog_len]   = m_status;
		prog_len++;
	endtask

	task automatic put_mov_imm(logic [2:0] rn, logic [7:0] imm);
		emit(encode(3'b110, 2'b10, rn, imm[7:5], imm[4:3], imm[2:0]), 5);
		m_regs[rn] = {{8{imm[7]}}, imm};
	endtask

	task automatic put_mov_reg(logic [2:0] rd, logic [1:0] sh, logic [2:0] rm);
		emit(encode(3'b110, 2'b00, 3'd0, rd, sh, rm), 7);
		m_regs[rd] = shift_val(m_regs[rm], sh);
	endtask

	task automatic put_alu(logic [1:0] op, logic [2:0] rd, logic [2:0] rn, logic [1:0] sh,
			logic [2:0] rm);
		cpu_pkg::word_t a, b, r;
		a = m_regs[rn];
		b = shift_val(m_regs[rm], sh);
		emit(encode(3'b101, op, rn, rd, sh, rm), (op == 2'b01) ? 7 : 8);
		case (op)
			2'b00:   r = a + b;
			2'b01:   r = a - b;
			2'b10:   r = a & b;
			default: r = ~b;
		endcase
		if (op == 2'b01)
			m_status = {r == 16'd0, r[15], (a[15] != b[15]) && (r[15] != a[15])};
		else
			m_regs[rd] = r;
	endtask

	task automatic put_str(logic [2:0] rd, logic [2:0] rn, logic [4:0] imm5);
		cpu_pkg::word_t addr;
		emit(encode(3'b100, 2'b00, rn, rd, imm5[4:3], imm5[2:0]), 9);
		addr = m_regs[rn] + {{11{imm5[4]}}, imm5};
		mem_inst.exp_addr[str_count] = addr[8:0];
		mem_inst.exp_data[str_count] = m_regs[rd];
		str_count++;
		mem_inst.exp_count = str_count;
	endtask

	task automatic build_program();
		integer r;
		mem_inst.fill_pattern();
		put_mov_imm(3'd3, 8'h50); // Store base well above the program.
		r = $random(seed);
		put_mov_imm(3'd0, r[7:0]);
		put_str(3'd0, 3'd3, 5'h1d);
		r = $random(seed);
		put_mov_imm(3'd1, r[7:0]);
		r = $random(seed);
		put_mov_imm(3'd2, r[7:0]);
		put_alu(2'b01, 3'd0, 3'd0, 2'b00, 3'd0); // Equal operands.
		put_alu(2'b00, 3'd4, 3'd0, 2'b01, 3'd1);
		put_str(3'd4, 3'd3, 5'h01);
		put_mov_imm(3'd4, 8'h10);
		put_mov_imm(3'd5, 8'h20);
		put_alu(2'b01, 3'd0, 3'd4, 2'b00, 3'd5); // Negative result.
		put_alu(2'b10, 3'd5, 3'd1, 2'b10, 3'd2);
		put_str(3'd5, 3'd3, 5'h02);
		put_mov_imm(3'd6, 8'h80);
		put_alu(2'b11, 3'd7, 3'd0, 2'b10, 3'd6);
		put_mov_imm(3'd5, 8'h40);
		put_alu(2'b01, 3'd0, 3'd7, 2'b00, 3'd5); // Signed overflow.
		put_alu(2'b11, 3'd6, 3'd0, 2'b11, 3'd2);
		put_str(3'd6, 3'd3, 5'h04);
		put_mov_reg(3'd7, 2'b00, 3'd1);
		put_str(3'd7, 3'd3, 5'h10);
		emit(encode(3'b111, 2'b00, 3'd0, 3'd0, 2'b00, 3'd0), 0);
	endtask

	task automatic wait_for_halt(output bit ok);
		ok = 1'b0;
		for (int i = 0; i < 400 && !ok; i++) begin
			@(posedge clk);
			ok = halt;
		end
	endtask

	task automatic wait_for_fetch(int target, output bit ok);
		ok = 1'b0;
		for (int i = 0; i < 200 && !ok; i++) begin
			@(posedge clk);
			ok = (exp_pc >= target);
		end
	endtask

	task automatic pulse_reset();
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1 rst = 1'b0;
	endtask

	initial begin
		bit ok;
		build_program();
		pulse_reset();
		wait_for_halt(ok);
		if (!ok) begin
			timeouts++;
			$display("Timed out waiting for halt.");
		end else begin
			repeat (20) @(posedge clk); // Bus must stay idle.
			a_store_count: assert (mem_inst.write_count == str_count)
				else begin
					errors++;
					$display("** Error @%0t: %0d stores seen, expected %0d",
						$time, mem_inst.write_count, str_count);
				end
			#1;
			pulse_reset();
			wait_for_fetch(3, ok);
			if (!ok) begin
				timeouts++;
				$display("Timed out waiting for fetch after second reset.");
			end
		end
		$display("Errors: checks %0d, memory %0d, timeouts %0d",
			errors, mem_inst.err_count, timeouts);
		if (errors == 0 && mem_inst.err_count == 0 && timeouts == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/tb_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem (
	input  wire logic                clk,
	input  wire cpu_pkg::mem_addr_t  mem_addr,
	input  wire cpu_pkg::mem_cmd_t   mem_cmd,
	input  wire cpu_pkg::word_t      mem_wdata,
	output cpu_pkg::word_t           mem_rdata = '0
);

	localparam int DEPTH = 1 << cpu_pkg::MEM_ADDR_W;

	cpu_pkg::word_t     mem [DEPTH];
	cpu_pkg::mem_addr_t exp_addr [64]; // Expected stores in program order.
	cpu_pkg::word_t     exp_data [64];
	int exp_count   = 0;
	int write_count = 0;
	int err_count   = 0;

	// Background pattern that depends on every address bit.
	task automatic fill_pattern();
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = {i[8:0], i[6:0]} ^ 16'h5a5a;
		end
	endtask

	// Registered read.
	always @(posedge clk) begin
		if (mem_cmd == cpu_pkg::MEM_READ)
			mem_rdata <= mem[mem_addr];
	end

	always @(posedge clk) begin
		if (mem_cmd == cpu_pkg::MEM_WRITE) begin
			mem[mem_addr] <= mem_wdata;
			write_count   <= write_count + 1;
		end
	end

	a_store_expected: assert property (@(posedge clk)
		mem_cmd == cpu_pkg::MEM_WRITE |-> write_count < exp_count)
		else begin
			err_count++;
			$display("Store number %0d at %0t was not expected by the program.",
				$sampled(write_count), $time);
		end

	a_store_value: assert property (@(posedge clk)
		mem_cmd == cpu_pkg::MEM_WRITE && write_count < exp_count |->
			mem_addr == exp_addr[write_count] && mem_wdata == exp_data[write_count])
		else begin
			err_count++;
			$display("** Error @%0t: store %0d wrote %h at %h, expected %h at %h",
				$time, $sampled(write_count), $sampled(mem_wdata), $sampled(mem_addr),
				exp_data[$sampled(write_count)], exp_addr[$sampled(write_count)]);
		end

endmodule

`default_nettype wire

// ==== logic/cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire cpu_pkg::word_t   mem_rdata,
	output cpu_pkg::mem_addr_t    mem_addr,
	output cpu_pkg::mem_cmd_t     mem_cmd,
	output cpu_pkg::word_t        mem_wdata,
	output logic [2:0]            status,
	output logic                  halt
);

	// Control strobes.
	logic reset_pc, load_pc, load_ir, addr_sel, load_addr;
	logic loada, loadb, loadc, loads, asel, bsel, write;
	cpu_pkg::wb_sel_t wb_sel;
	cpu_pkg::nsel_t   nsel;

	// Decoded instruction fields.
	cpu_pkg::opcode_t  opcode;
	cpu_pkg::alu_op_t  op;
	cpu_pkg::reg_idx_t reg_num;
	cpu_pkg::shift_t   shift;
	cpu_pkg::word_t    sximm5, sximm8;

	cpu_pkg::word_t reg_data, wb_data, c_out;

	cpu_control cpu_control_inst (
		.clk       (clk),
		.rst       (rst),
		.opcode    (opcode),
		.op        (op),
		.reset_pc  (reset_pc),
		.load_pc   (load_pc),
		.load_ir   (load_ir),
		.addr_sel  (addr_sel),
		.load_addr (load_addr),
		.loada     (loada),
		.loadb     (loadb),
		.loadc     (loadc),
		.loads     (loads),
		.asel      (asel),
		.bsel      (bsel),
		.write     (write),
		.wb_sel    (wb_sel),
		.nsel      (nsel),
		.mem_cmd   (mem_cmd),
		.halt      (halt)
	);

	instr_reg instr_reg_inst (
		.clk       (clk),
		.load_ir   (load_ir),
		.mem_rdata (mem_rdata),
		.nsel      (nsel),
		.opcode    (opcode),
		.op        (op),
		.reg_num   (reg_num),
		.shift     (shift),
		.sximm5    (sximm5),
		.sximm8    (sximm8)
	);

	reg_file reg_file_inst (
		.clk      (clk),
		.write    (write),
		.reg_num  (reg_num),
		.data_in  (wb_data),
		.data_out (reg_data)
	);

	alu_datapath alu_datapath_inst (
		.clk      (clk),
		.rst      (rst),
		.loada    (loada),
		.loadb    (loadb),
		.loadc    (loadc),
		.loads    (loads),
		.asel     (asel),
		.bsel     (bsel),
		.wb_sel   (wb_sel),
		.op       (op),
		.shift    (shift),
		.reg_data (reg_data),
		.sximm5   (sximm5),
		.sximm8   (sximm8),
		.wb_data  (wb_data),
		.c_out    (c_out),
		.status   (status)
	);

	addr_unit addr_unit_inst (
		.clk       (clk),
		.reset_pc  (reset_pc),
		.load_pc   (load_pc),
		.addr_sel  (addr_sel),
		.load_addr (load_addr),
		.c_out     (c_out),
		.mem_addr  (mem_addr)
	);

	assign mem_wdata = c_out; // Store data leaves through C.

endmodule

`default_nettype wire

// ==== logic/addr_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module addr_unit (
	input  wire logic           clk,
	input  wire logic           reset_pc,
	input  wire logic           load_pc,
	input  wire logic           addr_sel,
	input  wire logic           load_addr,
	input  wire cpu_pkg::word_t c_out,
	output cpu_pkg::mem_addr_t  mem_addr
);

	cpu_pkg::mem_addr_t pc;
	cpu_pkg::mem_addr_t data_addr;

	always_ff @(posedge clk) begin
		if (load_pc)
			pc <= reset_pc ? '0 : pc + 1'b1;
	end

	// Low bits of the computed address only.
	always_ff @(posedge clk) begin
		if (load_addr)
			data_addr <= c_out[cpu_pkg::MEM_ADDR_W-1:0];
	end

	assign mem_addr = addr_sel ? pc : data_addr; // Fetch or data access.

	// The controller clears the PC through the load path.
	a_reset_with_load: assert property (@(posedge clk) reset_pc |-> load_pc)
		else $error("reset_pc without load_pc.");

endmodule

`default_nettype wire

// ==== logic/alu_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_datapath (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             loada,
	input  wire logic             loadb,
	input  wire logic             loadc,
	input  wire logic             loads,
	input  wire logic             asel,
	input  wire logic             bsel,
	input  wire cpu_pkg::wb_sel_t wb_sel,
	input  wire cpu_pkg::alu_op_t op,
	input  wire cpu_pkg::shift_t  shift,
	input  wire cpu_pkg::word_t   reg_data,
	input  wire cpu_pkg::word_t   sximm5,
	input  wire cpu_pkg::word_t   sximm8,
	output cpu_pkg::word_t        wb_data,
	output cpu_pkg::word_t        c_out,
	output logic [2:0]            status // {Z, N, V}.
);

	localparam int MSB = cpu_pkg::WORD_W - 1;

	cpu_pkg::word_t a_q, b_q, c_q;
	cpu_pkg::word_t b_sh, ain, bin, b_eff, alu_out;
	logic zero, neg, ovf;

	always_ff @(posedge clk) begin
		if (loada)
			a_q <= reg_data;
		if (loadb)
			b_q <= reg_data;
		if (loadc)
			c_q <= alu_out;
	end

	always_ff @(posedge clk) begin
		if (rst)
			status <= '0;
		else if (loads)
			status <= {zero, neg, ovf};
	end

	always_comb begin
		case (shift)
			cpu_pkg::SH_LSL: b_sh = {b_q[MSB-1:0], 1'b0};
			cpu_pkg::SH_LSR: b_sh = {1'b0, b_q[MSB:1]};
			cpu_pkg::SH_ASR: b_sh = {b_q[MSB], b_q[MSB:1]};
			default:         b_sh = b_q;
		endcase
	end

	assign ain = asel ? '0 : a_q;
	assign bin = bsel ? sximm5 : b_sh;

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD: alu_out = ain + bin;
			cpu_pkg::ALU_SUB: alu_out = ain - bin;
			cpu_pkg::ALU_AND: alu_out = ain & bin;
			default:          alu_out = ~bin;
		endcase
	end

	// Subtraction overflows like an add of the inverted operand.
	assign b_eff = (op == cpu_pkg::ALU_SUB) ? ~bin : bin;
	assign ovf   = (ain[MSB] == b_eff[MSB]) && (alu_out[MSB] != ain[MSB]);
	assign zero  = (alu_out == '0);
	assign neg   = alu_out[MSB];

	assign c_out   = c_q;
	assign wb_data = (wb_sel == cpu_pkg::WB_IMM) ? sximm8 : c_q; // MOV immediate path.

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
	input  wire logic              clk,
	input  wire logic              write,
	input  wire cpu_pkg::reg_idx_t reg_num,
	input  wire cpu_pkg::word_t    data_in,
	output cpu_pkg::word_t         data_out
);

	cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

	// Single address serves both ports.
	always_ff @(posedge clk) begin
		if (write)
			regs[reg_num] <= data_in;
	end

	assign data_out = regs[reg_num]; // Combinational read.

	a_write_known: assert property (@(posedge clk) !$isunknown(write))
		else $error("Register write strobe unknown.");

	a_write_data: assert property (@(posedge clk)
		write |-> !$isunknown(data_in))
		else $error("Unknown data written to register file.");

endmodule

`default_nettype wire

// ==== logic/instr_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_reg (
	input  wire logic             clk,
	input  wire logic             load_ir,
	input  wire cpu_pkg::word_t   mem_rdata,
	input  wire cpu_pkg::nsel_t   nsel,
	output cpu_pkg::opcode_t      opcode,
	output cpu_pkg::alu_op_t      op,
	output cpu_pkg::reg_idx_t     reg_num,
	output cpu_pkg::shift_t       shift,
	output cpu_pkg::word_t        sximm5,
	output cpu_pkg::word_t        sximm8
);

	localparam int RW = $bits(cpu_pkg::reg_idx_t);

	cpu_pkg::word_t    ir;
	cpu_pkg::reg_idx_t rn, rd, rm;

	always_ff @(posedge clk) begin
		if (load_ir)
			ir <= mem_rdata;
	end

	assign opcode = cpu_pkg::opcode_t'(ir[cpu_pkg::OPC_LSB +: $bits(cpu_pkg::opcode_t)]);
	assign op     = cpu_pkg::alu_op_t'(ir[cpu_pkg::OP_LSB +: $bits(cpu_pkg::alu_op_t)]);

	assign rn = ir[cpu_pkg::RN_LSB +: RW];
	assign rd = ir[cpu_pkg::RD_LSB +: RW];
	assign rm = ir[cpu_pkg::RM_LSB +: RW];

	// One-hot mux over the three register fields.
	assign reg_num = ({RW{nsel == cpu_pkg::SEL_RN}} & rn)
		| ({RW{nsel == cpu_pkg::SEL_RD}} & rd)
		| ({RW{nsel == cpu_pkg::SEL_RM}} & rm);

	// In STR these bits belong to imm5, so no shift is applied.
	assign shift = (opcode == cpu_pkg::OPC_STR) ? cpu_pkg::SH_NONE
		: cpu_pkg::shift_t'(ir[cpu_pkg::SH_LSB +: $bits(cpu_pkg::shift_t)]);

	assign sximm5 = {{(cpu_pkg::WORD_W-cpu_pkg::IMM5_W){ir[cpu_pkg::IMM5_W-1]}},
		ir[cpu_pkg::IMM5_W-1:0]};
	assign sximm8 = {{(cpu_pkg::WORD_W-cpu_pkg::IMM8_W){ir[cpu_pkg::IMM8_W-1]}},
		ir[cpu_pkg::IMM8_W-1:0]};

endmodule

`default_nettype wire

// ==== logic/cpu_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_control (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire cpu_pkg::opcode_t opcode,
	input  wire cpu_pkg::alu_op_t op,
	output logic               reset_pc,
	output logic               load_pc,
	output logic               load_ir,
	output logic               addr_sel,
	output logic               load_addr,
	output logic               loada,
	output logic               loadb,
	output logic               loadc,
	output logic               loads,
	output logic               asel,
	output logic               bsel,
	output logic               write,
	output cpu_pkg::wb_sel_t   wb_sel,
	output cpu_pkg::nsel_t     nsel,
	output cpu_pkg::mem_cmd_t  mem_cmd,
	output logic               halt
);

	cpu_pkg::state_t state, next_state;
	logic mov_imm;

	// MOV immediate shares its op code with AND.
	assign mov_imm = (opcode == cpu_pkg::OPC_MOV) && (op == cpu_pkg::ALU_AND);

	always_ff @(posedge clk) begin
		if (rst)
			state <= cpu_pkg::S_RESET;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			cpu_pkg::S_RESET:  next_state = cpu_pkg::S_IF1;
			cpu_pkg::S_IF1:    next_state = cpu_pkg::S_IF2;
			cpu_pkg::S_IF2:    next_state = cpu_pkg::S_UPDATE;
			cpu_pkg::S_UPDATE: next_state = cpu_pkg::S_DEC;
			cpu_pkg::S_DEC: begin
				case (opcode)
					cpu_pkg::OPC_MOV:  next_state = mov_imm ? cpu_pkg::S_WRITE : cpu_pkg::S_B;
					cpu_pkg::OPC_ALU:  next_state = cpu_pkg::S_A;
					cpu_pkg::OPC_STR:  next_state = cpu_pkg::S_A;
					cpu_pkg::OPC_HALT: next_state = cpu_pkg::S_HALT;
					default:           next_state = cpu_pkg::S_IF1; // Unknown opcode is skipped.
				endcase
			end
			cpu_pkg::S_A:
				next_state = (opcode == cpu_pkg::OPC_STR) ? cpu_pkg::S_C : cpu_pkg::S_B;
			cpu_pkg::S_B:
				next_state = (op == cpu_pkg::ALU_SUB) ? cpu_pkg::S_STATUS : cpu_pkg::S_C;
			cpu_pkg::S_C:
				next_state = (opcode == cpu_pkg::OPC_STR) ? cpu_pkg::S_ADDR : cpu_pkg::S_WRITE;
			cpu_pkg::S_ADDR:   next_state = cpu_pkg::S_C2;
			cpu_pkg::S_C2:     next_state = cpu_pkg::S_MEMW;
			cpu_pkg::S_MEMW,
			cpu_pkg::S_STATUS,
			cpu_pkg::S_WRITE:  next_state = cpu_pkg::S_IF1;
			cpu_pkg::S_HALT:   next_state = cpu_pkg::S_HALT; // Only rst leaves.
			default:           next_state = cpu_pkg::S_RESET;
		endcase
	end

	always_comb begin
		reset_pc  = 1'b0;
		load_pc   = 1'b0;
		load_ir   = 1'b0;
		addr_sel  = 1'b0;
		load_addr = 1'b0;
		loada     = 1'b0;
		loadb     = 1'b0;
		loadc     = 1'b0;
		loads     = 1'b0;
		asel      = 1'b0;
		bsel      = 1'b0;
		write     = 1'b0;
		wb_sel    = cpu_pkg::WB_C;
		nsel      = cpu_pkg::SEL_RN;
		mem_cmd   = cpu_pkg::MEM_NONE;
		halt      = 1'b0;
		case (state)
			cpu_pkg::S_RESET: begin
				reset_pc = 1'b1;
				load_pc  = 1'b1;
			end
			cpu_pkg::S_IF1: begin
				addr_sel = 1'b1;
				mem_cmd  = cpu_pkg::MEM_READ;
			end
			cpu_pkg::S_IF2: begin
				addr_sel = 1'b1;
				mem_cmd  = cpu_pkg::MEM_READ;
				load_ir  = 1'b1; // Word from the S_IF1 read is on mem_rdata.
			end
			cpu_pkg::S_UPDATE: load_pc = 1'b1;
			cpu_pkg::S_A: begin
				nsel  = cpu_pkg::SEL_RN;
				loada = 1'b1;
			end
			cpu_pkg::S_B: begin
				nsel  = cpu_pkg::SEL_RM;
				loadb = 1'b1;
			end
			cpu_pkg::S_C: begin
				loadc = 1'b1;
				asel  = (opcode == cpu_pkg::OPC_MOV); // MOV register passes B alone.
				bsel  = (opcode == cpu_pkg::OPC_STR); // Rn plus sximm5.
			end
			cpu_pkg::S_STATUS: loads = 1'b1;
			cpu_pkg::S_WRITE: begin
				write  = 1'b1;
				wb_sel = mov_imm ? cpu_pkg::WB_IMM : cpu_pkg::WB_C;
				nsel   = mov_imm ? cpu_pkg::SEL_RN : cpu_pkg::SEL_RD;
			end
			// Address goes out of C while Rd is picked up for the store data.
			cpu_pkg::S_ADDR: begin
				load_addr = 1'b1;
				nsel      = cpu_pkg::SEL_RD;
				loadb     = 1'b1;
			end
			cpu_pkg::S_C2: begin
				asel  = 1'b1;
				loadc = 1'b1;
			end
			cpu_pkg::S_MEMW: mem_cmd = cpu_pkg::MEM_WRITE;
			cpu_pkg::S_HALT: halt = 1'b1;
			default: ;
		endcase
	end

	a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
		halt |=> mem_cmd == cpu_pkg::MEM_NONE)
		else $error("Memory command issued while halted.");

	a_halt_holds: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
		else $error("Halt dropped without reset.");

	// The store data must have come through C in the previous cycle.
	a_write_state: assert property (@(posedge clk) disable iff (rst)
		mem_cmd == cpu_pkg::MEM_WRITE |->
			state == cpu_pkg::S_MEMW && $past(state) == cpu_pkg::S_C2)
		else $error("MEM_WRITE outside S_MEMW.");

endmodule

`default_nettype wire

// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	localparam int WORD_W     = 16;
	localparam int NUM_REGS   = 8;
	localparam int MEM_ADDR_W = 9;

	// Low bit of each instruction field.
	localparam int OPC_LSB = 13;
	localparam int OP_LSB  = 11;
	localparam int RN_LSB  = 8;
	localparam int RD_LSB  = 5;
	localparam int SH_LSB  = 3;
	localparam int RM_LSB  = 0;

	// Immediates sit at bit 0.
	localparam int IMM8_W = 8;
	localparam int IMM5_W = 5;

	typedef logic [WORD_W-1:0]           word_t;
	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
	typedef logic [MEM_ADDR_W-1:0]       mem_addr_t;

	typedef enum logic [2:0] {
		OPC_STR  = 3'b100,
		OPC_ALU  = 3'b101,
		OPC_MOV  = 3'b110,
		OPC_HALT = 3'b111
	} opcode_t;

	// Same code space as the op field of ALU instructions.
	typedef enum logic [1:0] {
		ALU_ADD = 2'b00,
		ALU_SUB = 2'b01,
		ALU_AND = 2'b10,
		ALU_NOT = 2'b11
	} alu_op_t;

	typedef enum logic [1:0] {
		SH_NONE = 2'b00,
		SH_LSL  = 2'b01, // Left by one.
		SH_LSR  = 2'b10, // Logical right by one.
		SH_ASR  = 2'b11  // Arithmetic right by one.
	} shift_t;

	typedef enum logic [1:0] {
		MEM_NONE  = 2'b00,
		MEM_WRITE = 2'b01,
		MEM_READ  = 2'b10
	} mem_cmd_t;

	// One-hot register field select.
	typedef enum logic [2:0] {
		SEL_RN = 3'b001,
		SEL_RD = 3'b010,
		SEL_RM = 3'b100
	} nsel_t;

	typedef enum logic {
		WB_C   = 1'b0,
		WB_IMM = 1'b1
	} wb_sel_t;

	typedef enum logic [3:0] {
		S_RESET, S_IF1, S_IF2, S_UPDATE, S_DEC, S_A, S_B, S_C,
		S_STATUS, S_WRITE, S_ADDR, S_C2, S_MEMW, S_HALT
	} state_t;

endpackage

`default_nettype wire
